//--- design/stateDisc_config.svh
`ifndef STATEDISC_CONFIG_SVH
`define STATEDISC_CONFIG_SVH

// datapath widths
`define SD_SAMPLE_W 16
`define SD_ACC_W 32
`define SD_NORM_W 18
`define SD_SHIFT_W 5

// finished windows held between accumulator and normalizer
`define SD_FIFO_DEPTH 4

// APB register map, byte addresses
`define SD_ADDR_WINDOW 8'h00
`define SD_ADDR_OFFSETI 8'h04
`define SD_ADDR_OFFSETQ 8'h08
`define SD_ADDR_SHIFT 8'h0C
`define SD_ADDR_STATUS 8'h10
`define SD_ADDR_CTRL 8'h14

`endif

//--- design/stateDiscPkg.sv
`include "stateDisc_config.svh"

package stateDiscPkg;

    // raw ADC sample, two's complement
    typedef logic signed [`SD_SAMPLE_W-1:0] sampleT;

    // window sum, also used for the per-channel offsets
    typedef logic signed [`SD_ACC_W-1:0] accT;

    // classifier input word
    typedef logic signed [`SD_NORM_W-1:0] normT;

    typedef logic [`SD_SHIFT_W-1:0] shiftT;

    typedef logic [7:0] apbAddrT;

    // samples per window
    typedef logic [15:0] windowT;

endpackage

//--- design/apbParamRegs.sv
`timescale 1ns/1ps
`include "stateDisc_config.svh"

module apbParamRegs (
    input  logic                  sdif,
    input  logic                  rstN,
    input  stateDiscPkg::apbAddrT paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  overrunPulse,
    output stateDiscPkg::windowT  window,
    output logic                  enable,
    output stateDiscPkg::accT     offsetI,
    output stateDiscPkg::accT     offsetQ,
    output stateDiscPkg::shiftT   shiftI,
    output stateDiscPkg::shiftT   shiftQ
);

    logic access;
    logic wrEn;
    logic mapped;
    logic overrun;

    // zero wait states, access phase always completes
    assign pready = 1'b1;
    assign access = psel & penable;
    assign wrEn = access & pwrite;
    assign pslverr = access & ~mapped;

    // read mux, unmapped addresses return 0
    always_comb begin
        prdata = '0;
        mapped = 1'b1;
        case (paddr)
            `SD_ADDR_WINDOW: prdata[15:0] = window;
            `SD_ADDR_OFFSETI: prdata = offsetI;
            `SD_ADDR_OFFSETQ: prdata = offsetQ;
            `SD_ADDR_SHIFT: begin
                prdata[`SD_SHIFT_W-1:0] = shiftI;
                prdata[8 +: `SD_SHIFT_W] = shiftQ;
            end
            `SD_ADDR_STATUS: prdata[0] = overrun;
            `SD_ADDR_CTRL: prdata[0] = enable;
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge sdif) begin
        if (!rstN) begin
            window <= '0;
            enable <= 1'b0;
            offsetI <= '0;
            offsetQ <= '0;
            shiftI <= '0;
            shiftQ <= '0;
            overrun <= 1'b0;
        end else begin
            if (wrEn) begin
                case (paddr)
                    `SD_ADDR_WINDOW: window <= pwdata[15:0];
                    `SD_ADDR_OFFSETI: offsetI <= pwdata;
                    `SD_ADDR_OFFSETQ: offsetQ <= pwdata;
                    `SD_ADDR_SHIFT: begin
                        shiftI <= pwdata[`SD_SHIFT_W-1:0];
                        shiftQ <= pwdata[8 +: `SD_SHIFT_W];
                    end
                    `SD_ADDR_CTRL: enable <= pwdata[0];
                    default: ;
                endcase
            end
            // sticky overrun, a new event beats a clear in the same cycle
            if (overrunPulse) begin
                overrun <= 1'b1;
            end else if (wrEn && paddr == `SD_ADDR_STATUS && pwdata[0]) begin
                overrun <= 1'b0;
            end
        end
    end

endmodule

//--- design/iqAccumulator.sv
`timescale 1ns/1ps

module iqAccumulator (
    input  logic                 sdif,
    input  logic                 rstN,
    input  logic                 sampleValid,
    input  stateDiscPkg::sampleT sampleI,
    input  stateDiscPkg::sampleT sampleQ,
    input  stateDiscPkg::windowT window,
    input  logic                 enable,
    input  logic                 accReady,
    output logic                 accValid,
    output stateDiscPkg::accT    accI,
    output stateDiscPkg::accT    accQ,
    output logic                 overrunPulse
);

    stateDiscPkg::accT sumI;
    stateDiscPkg::accT sumQ;
    stateDiscPkg::accT nextI;
    stateDiscPkg::accT nextQ;
    stateDiscPkg::windowT count;
    stateDiscPkg::windowT lastIdx;
    logic slotFree;
    logic take;
    logic discard;
    logic windowDone;
    logic overrunSeen;

    // a zero window behaves like a one-sample window
    assign lastIdx = (window == '0) ? '0 : window - 1'b1;

    // pending result leaving this cycle frees the output slot
    assign slotFree = ~accValid | accReady;
    assign take = enable & sampleValid & slotFree;
    assign discard = enable & sampleValid & ~slotFree;
    assign windowDone = take & (count >= lastIdx);

    assign nextI = sumI + stateDiscPkg::accT'(sampleI);
    assign nextQ = sumQ + stateDiscPkg::accT'(sampleQ);

    always_ff @(posedge sdif) begin
        if (!rstN) begin
            sumI <= '0;
            sumQ <= '0;
            count <= '0;
            accValid <= 1'b0;
            overrunSeen <= 1'b0;
            overrunPulse <= 1'b0;
        end else begin
            // one pulse per pending period
            overrunPulse <= discard & ~overrunSeen;
            if (accValid && accReady) begin
                accValid <= 1'b0;
                overrunSeen <= 1'b0;
            end else if (discard) begin
                overrunSeen <= 1'b1;
            end

            if (!enable) begin
                // disabled, restart from an empty window
                sumI <= '0;
                sumQ <= '0;
                count <= '0;
            end else if (windowDone) begin
                sumI <= '0;
                sumQ <= '0;
                count <= '0;
                accValid <= 1'b1;
            end else if (take) begin
                sumI <= nextI;
                sumQ <= nextQ;
                count <= count + 1'b1;
            end
        end
    end

    // finished pair, held until the FIFO takes it
    always_ff @(posedge sdif) begin
        if (windowDone) begin
            accI <= nextI;
            accQ <= nextQ;
        end
    end

endmodule

//--- design/iqFifo.sv
`timescale 1ns/1ps
`include "stateDisc_config.svh"

module iqFifo (
    input  logic              sdif,
    input  logic              rstN,
    input  logic              accValid,
    input  stateDiscPkg::accT accI,
    input  stateDiscPkg::accT accQ,
    input  logic              pop,
    output logic              accReady,
    output logic              fifoValid,
    output stateDiscPkg::accT fifoI,
    output stateDiscPkg::accT fifoQ
);

    localparam int depth = `SD_FIFO_DEPTH;
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    stateDiscPkg::accT memI [depth];
    stateDiscPkg::accT memQ [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic push;
    logic popDo;

    // circular increment, depth need not be a power of two
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p);
        if (p == ptrW'(depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign accReady = (count != cntW'(depth));
    assign fifoValid = (count != '0);
    assign push = accValid & accReady;
    assign popDo = pop & fifoValid;

    // first word fall through
    assign fifoI = memI[rdPtr];
    assign fifoQ = memQ[rdPtr];

    always_ff @(posedge sdif) begin
        if (push) begin
            memI[wrPtr] <= accI;
            memQ[wrPtr] <= accQ;
        end
    end

    always_ff @(posedge sdif) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popDo) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, popDo})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

//--- design/iqNormalizer.sv
`timescale 1ns/1ps
`include "stateDisc_config.svh"

module iqNormalizer (
    input  logic                sdif,
    input  logic                rstN,
    input  logic                fifoValid,
    input  stateDiscPkg::accT   fifoI,
    input  stateDiscPkg::accT   fifoQ,
    input  stateDiscPkg::accT   offsetI,
    input  stateDiscPkg::accT   offsetQ,
    input  stateDiscPkg::shiftT shiftI,
    input  stateDiscPkg::shiftT shiftQ,
    input  logic                outReady,
    output logic                pop,
    output stateDiscPkg::normT  outI,
    output stateDiscPkg::normT  outQ,
    output logic                nnStart
);

    // one extra bit so acc plus offset never wraps
    localparam int wideW = `SD_ACC_W + 1;
    localparam logic signed [wideW-1:0] normMax = (2 ** (`SD_NORM_W - 1)) - 1;
    localparam logic signed [wideW-1:0] normMin = -(2 ** (`SD_NORM_W - 1));

    logic signed [wideW-1:0] sum1I;
    logic signed [wideW-1:0] sum1Q;
    logic signed [wideW-1:0] shift2I;
    logic signed [wideW-1:0] shift2Q;
    logic stage1Valid;
    logic stage2Valid;
    logic stage3Valid;

    function automatic stateDiscPkg::normT saturate(input logic signed [wideW-1:0] x);
        if (x > normMax) begin
            return normMax[`SD_NORM_W-1:0];
        end
        if (x < normMin) begin
            return normMin[`SD_NORM_W-1:0];
        end
        return x[`SD_NORM_W-1:0];
    endfunction

    // whole pipeline moves as one, so a pop needs only outReady
    assign pop = fifoValid & outReady;
    assign nnStart = stage3Valid;

    // valid bits carry the start strobe alongside the data
    always_ff @(posedge sdif) begin
        if (!rstN) begin
            stage1Valid <= 1'b0;
            stage2Valid <= 1'b0;
            stage3Valid <= 1'b0;
        end else if (outReady) begin
            stage1Valid <= pop;
            stage2Valid <= stage1Valid;
            stage3Valid <= stage2Valid;
        end
    end

    always_ff @(posedge sdif) begin
        if (outReady) begin
            // stage 1, offset at widened precision
            sum1I <= wideW'(fifoI) + wideW'(offsetI);
            sum1Q <= wideW'(fifoQ) + wideW'(offsetQ);
            // stage 2, arithmetic shift keeps the sign
            shift2I <= sum1I >>> shiftI;
            shift2Q <= sum1Q >>> shiftQ;
            // stage 3, clamp to the 18 bit range
            outI <= saturate(shift2I);
            outQ <= saturate(shift2Q);
        end
    end

endmodule

//--- design/stateDiscFrontEnd.sv
`timescale 1ns/1ps

module stateDiscFrontEnd (
    input  logic                  sdif,
    input  logic                  rstN,
    input  stateDiscPkg::apbAddrT paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  sampleValid,
    input  stateDiscPkg::sampleT  sampleI,
    input  stateDiscPkg::sampleT  sampleQ,
    output stateDiscPkg::normT    outI,
    output stateDiscPkg::normT    outQ,
    output logic                  nnStart,
    input  logic                  outReady
);

    // configuration
    stateDiscPkg::windowT window;
    logic enable;
    stateDiscPkg::accT offsetI;
    stateDiscPkg::accT offsetQ;
    stateDiscPkg::shiftT shiftI;
    stateDiscPkg::shiftT shiftQ;
    logic overrunPulse;

    // accumulator to FIFO
    logic accValid;
    logic accReady;
    stateDiscPkg::accT accI;
    stateDiscPkg::accT accQ;

    // FIFO to normalizer
    logic fifoValid;
    logic pop;
    stateDiscPkg::accT fifoI;
    stateDiscPkg::accT fifoQ;

    apbParamRegs i_apbParamRegs (
        .sdif(sdif), .rstN(rstN), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .overrunPulse(overrunPulse), .window(window), .enable(enable),
        .offsetI(offsetI), .offsetQ(offsetQ), .shiftI(shiftI), .shiftQ(shiftQ)
    );

    iqAccumulator i_iqAccumulator (
        .sdif(sdif), .rstN(rstN), .sampleValid(sampleValid), .sampleI(sampleI),
        .sampleQ(sampleQ), .window(window), .enable(enable), .accReady(accReady),
        .accValid(accValid), .accI(accI), .accQ(accQ), .overrunPulse(overrunPulse)
    );

    iqFifo i_iqFifo (
        .sdif(sdif), .rstN(rstN), .accValid(accValid), .accI(accI), .accQ(accQ),
        .pop(pop), .accReady(accReady), .fifoValid(fifoValid), .fifoI(fifoI), .fifoQ(fifoQ)
    );

    iqNormalizer i_iqNormalizer (
        .sdif(sdif), .rstN(rstN), .fifoValid(fifoValid), .fifoI(fifoI), .fifoQ(fifoQ),
        .offsetI(offsetI), .offsetQ(offsetQ), .shiftI(shiftI), .shiftQ(shiftQ),
        .outReady(outReady), .pop(pop), .outI(outI), .outQ(outQ), .nnStart(nnStart)
    );

endmodule

//--- bench/stateDisc_asserts.sv
`timescale 1ns/1ps
`include "stateDisc_config.svh"

module stateDiscAsserts (
    input logic        sdif,
    input logic        rstN,
    input logic        validIn,
    input logic        readyIn,
    input logic        popIn,
    input logic        notEmpty,
    input logic        stallN,
    input logic [7:0]  level,
    input logic [63:0] holdWord
);

    // offered result stays up until it is taken
    validHold: assert property (@(posedge sdif) disable iff (!rstN)
        validIn && !readyIn |=> validIn)
        else $error("valid dropped before it was accepted");

    levelCap: assert property (@(posedge sdif) disable iff (!rstN)
        level <= 8'(`SD_FIFO_DEPTH))
        else $error("FIFO occupancy above its depth");

    // a push while full must leave the count alone
    fullHold: assert property (@(posedge sdif) disable iff (!rstN)
        level == 8'(`SD_FIFO_DEPTH) && !popIn |=> level == 8'(`SD_FIFO_DEPTH))
        else $error("FIFO accepted a push while full");

    popGuard: assert property (@(posedge sdif) disable iff (!rstN)
        popIn |-> notEmpty)
        else $error("pop without fifoValid");

    holdStall: assert property (@(posedge sdif) disable iff (!rstN)
        !stallN |=> $stable(holdWord))
        else $error("outputs changed while outReady was low");

endmodule

bind iqFifo stateDiscAsserts fifoChecks (
    .sdif(sdif), .rstN(rstN), .validIn(accValid), .readyIn(accReady), .popIn(pop),
    .notEmpty(fifoValid), .stallN(1'b1), .level(8'(count)), .holdWord(64'd0)
);

bind iqNormalizer stateDiscAsserts normChecks (
    .sdif(sdif), .rstN(rstN), .validIn(1'b0), .readyIn(1'b1), .popIn(pop),
    .notEmpty(fifoValid), .stallN(outReady), .level(8'd0),
    .holdWord(64'({nnStart, outI, outQ}))
);

//--- bench/stateDiscTb.sv
`timescale 1ns/1ps
`include "stateDisc_config.svh"

module stateDiscTb;

    typedef struct packed {
        stateDiscPkg::windowT window;
        stateDiscPkg::accT offI;
        stateDiscPkg::accT offQ;
        stateDiscPkg::shiftT shI;
        stateDiscPkg::shiftT shQ;
        int windows;
        int range;
        logic [7:0] stall;
    } rowT;

    localparam int numRows = 5;

    logic sdif;
    logic rstN;
    stateDiscPkg::apbAddrT paddr;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic sampleValid;
    stateDiscPkg::sampleT sampleI;
    stateDiscPkg::sampleT sampleQ;
    stateDiscPkg::normT outI;
    stateDiscPkg::normT outQ;
    logic nnStart;
    logic outReady = 1'b0;

    logic [7:0] stallBits;
    logic [2:0] phase = 3'd0;
    rowT rows [numRows];
    stateDiscPkg::normT expI [$];
    stateDiscPkg::normT expQ [$];
    integer seed;
    int cycles = 0;
    int limit;

    stateDiscFrontEnd i_stateDiscFrontEnd (.*);

    initial begin
        sdif = 1'b0;
        forever #2 sdif = ~sdif;
    end

    // classifier back-pressure follows the row's 8-cycle pattern
    always @(posedge sdif) begin
        phase <= phase + 3'd1;
        outReady <= stallBits[phase];
    end

    always @(posedge sdif) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            stopWithFailure("timeout: the expected results did not arrive within the cycle limit");
        end
    end

    // an output counts once, on the cycle the classifier takes it
    always @(negedge sdif) begin
        if (rstN && nnStart && outReady) begin
            if (expI.size() == 0) begin
                stopWithFailure("nnStart was raised while no result was expected");
            end else begin
                checkNorm("outI", expI.pop_front(), outI);
                checkNorm("outQ", expQ.pop_front(), outQ);
            end
        end
    end

    task automatic stopWithFailure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic checkNorm(input string name, input stateDiscPkg::normT expVal,
                             input stateDiscPkg::normT actVal);
        if (actVal !== expVal) begin
            stopWithFailure($sformatf("[FAIL] %s expected %h got %h", name, expVal, actVal));
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] expVal,
                             input logic [31:0] actVal);
        if (actVal !== expVal) begin
            stopWithFailure($sformatf("[FAIL] %s expected %h got %h", name, expVal, actVal));
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            stopWithFailure($sformatf("[FAIL] %s expected %h got %h", name, expVal, actVal));
        end
    endtask

    // offset at full precision, arithmetic shift, clamp to 18 bits signed
    function automatic stateDiscPkg::normT expectedNorm(input longint acc,
                                                       input stateDiscPkg::accT off,
                                                       input stateDiscPkg::shiftT sh);
        longint maxV;
        longint v;
        maxV = (longint'(1) <<< (`SD_NORM_W - 1)) - 1;
        v = (acc + longint'(off)) >>> sh;
        if (v > maxV) begin
            v = maxV;
        end else if (v < -maxV - 1) begin
            v = -maxV - 1;
        end
        return stateDiscPkg::normT'(v);
    endfunction

    task automatic apbWrite(input stateDiscPkg::apbAddrT addr, input logic [31:0] data);
        @(posedge sdif);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b1;
        paddr <= addr;
        pwdata <= data;
        @(posedge sdif);
        penable <= 1'b1;
        @(posedge sdif);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbRead(input stateDiscPkg::apbAddrT addr, output logic [31:0] data,
                           output logic err);
        @(posedge sdif);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= addr;
        @(posedge sdif);
        penable <= 1'b1;
        @(negedge sdif);
        data = prdata;
        err = pslverr;
        checkFlag("pready", 1'b1, pready);
        @(posedge sdif);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic runRow(input rowT r);
        int effW;
        int n;
        longint sumI;
        longint sumQ;
        stateDiscPkg::sampleT sI;
        stateDiscPkg::sampleT sQ;
        logic [31:0] d;
        logic err;
        effW = (r.window == 16'd0) ? 1 : int'(r.window);
        apbWrite(`SD_ADDR_CTRL, 32'd0);
        apbWrite(`SD_ADDR_WINDOW, 32'(r.window));
        apbWrite(`SD_ADDR_OFFSETI, r.offI);
        apbWrite(`SD_ADDR_OFFSETQ, r.offQ);
        apbWrite(`SD_ADDR_SHIFT, 32'({r.shQ, 3'b000, r.shI}));
        apbWrite(`SD_ADDR_CTRL, 32'd1);
        stallBits <= r.stall;
        sumI = 0;
        sumQ = 0;
        n = 0;
        // fully stalled row lets three results into the normalizer once the FIFO has
        // filled, then sends one window more than the whole chain can hold
        for (int k = 0; k < (r.windows + ((r.stall == 8'h00) ? 1 : 0)) * effW; k++) begin
            sI = stateDiscPkg::sampleT'($random(seed) % r.range);
            sQ = stateDiscPkg::sampleT'($random(seed) % r.range);
            @(posedge sdif);
            sampleValid <= 1'b1;
            sampleI <= sI;
            sampleQ <= sQ;
            if (r.stall == 8'h00 && k == `SD_FIFO_DEPTH * effW) begin
                stallBits <= 8'hFF;
            end else if (r.stall == 8'h00 && k == `SD_FIFO_DEPTH * effW + 3) begin
                stallBits <= 8'h00;
            end
            if (k < r.windows * effW) begin
                sumI += longint'(sI);
                sumQ += longint'(sQ);
                n++;
                if (n == effW) begin
                    expI.push_back(expectedNorm(sumI, r.offI, r.shI));
                    expQ.push_back(expectedNorm(sumQ, r.offQ, r.shQ));
                    sumI = 0;
                    sumQ = 0;
                    n = 0;
                end
            end
        end
        @(posedge sdif);
        sampleValid <= 1'b0;
        if (r.stall == 8'h00) begin
            stallBits <= 8'hFF;
        end
        while (expI.size() != 0) begin
            @(posedge sdif);
        end
        repeat (4) @(posedge sdif);
        apbRead(`SD_ADDR_STATUS, d, err);
        checkFlag("pslverr", 1'b0, err);
        checkWord("STATUS", (r.stall == 8'h00) ? 32'd1 : 32'd0, d);
        if (d[0]) begin
            apbWrite(`SD_ADDR_STATUS, 32'd1);
            apbRead(`SD_ADDR_STATUS, d, err);
            checkWord("STATUS after clear", 32'd0, d);
        end
    endtask

    initial begin
        logic [31:0] d;
        logic err;
        stateDiscPkg::apbAddrT regAddr [5];
        logic [31:0] regData [5];
        logic [31:0] regExp [5];
        regAddr = '{`SD_ADDR_WINDOW, `SD_ADDR_OFFSETI, `SD_ADDR_OFFSETQ, `SD_ADDR_SHIFT,
                    `SD_ADDR_CTRL};
        regData = '{32'hABCD_1234, 32'hDEAD_BEEF, 32'h8000_0001, 32'hFFFF_FFFF, 32'h3};
        regExp = '{32'h0000_1234, 32'hDEAD_BEEF, 32'h8000_0001, 32'h0000_1F1F, 32'h1};
        // window, offI, offQ, shI, shQ, windows, sample range, outReady pattern
        rows[0] = '{16'd4, 32'sd0, 32'sd0, 5'd0, 5'd0, 6, 1000, 8'hFF};
        rows[1] = '{16'd16, 32'sd65536, -32'sd100000, 5'd3, 5'd1, 5, 30000, 8'hFF};
        rows[2] = '{16'd0, 32'sh7FFF_FFFF, 32'sh8000_0000, 5'd0, 5'd0, 4, 100, 8'hFF};
        rows[3] = '{16'd8, -32'sd5000, 32'sd12345, 5'd2, 5'd4, 6, 20000, 8'b0110_1011};
        rows[4] = '{16'd6, 32'sd100, -32'sd100, 5'd1, 5'd1, 3 + `SD_FIFO_DEPTH + 1, 5000,
                    8'h00};
        limit = 0;
        for (int i = 0; i < numRows; i++) begin
            limit += rows[i].windows * ((rows[i].window == 16'd0) ? 1 : int'(rows[i].window)) * 2
                     + 100;
        end
        seed = 32'h925;
        rstN <= 1'b0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        paddr <= '0;
        pwdata <= '0;
        sampleValid <= 1'b0;
        sampleI <= '0;
        sampleQ <= '0;
        stallBits <= 8'hFF;
        repeat (2) @(posedge sdif);
        rstN <= 1'b1;

        for (int i = 0; i < 5; i++) begin
            apbWrite(regAddr[i], regData[i]);
            apbRead(regAddr[i], d, err);
            checkFlag("pslverr", 1'b0, err);
            checkWord($sformatf("register 0x%h", regAddr[i]), regExp[i], d);
        end
        apbRead(`SD_ADDR_STATUS, d, err);
        checkFlag("pslverr", 1'b0, err);
        checkWord("STATUS", 32'd0, d);
        apbRead(8'h18, d, err);
        if (!err) begin
            stopWithFailure("a read from an unmapped address did not raise pslverr");
        end
        checkWord("unmapped prdata", 32'd0, d);

        for (int i = 0; i < numRows; i++) begin
            runRow(rows[i]);
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- sources.f
+incdir+design
design/stateDiscPkg.sv
design/apbParamRegs.sv
design/iqAccumulator.sv
design/iqFifo.sv
design/iqNormalizer.sv
design/stateDiscFrontEnd.sv
bench/stateDisc_asserts.sv
bench/stateDiscTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the state discriminator front end testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -sv -f sources.f \
        --top-module stateDiscTb -o simStateDisc; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/simStateDisc > "$log" 2>&1; then
    cat "$log"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$log"

if grep -qx "Test OK" "$log"; then
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi
